/* bench/tb_axi_write_master.sv */
`timescale 1ns/1ps
`include "axi_wr_consts.svh"

module tb_axi_write_master;
  logic                       aclk;
  logic                       reset;
  logic                       ctrl_start;
  logic [`AXI_ADDR_W-1:0]     ctrl_addr;
  logic [`XFER_SIZE_W-1:0]    ctrl_size;
  logic                       ctrl_done;
  logic                       s_axis_tvalid;
  logic [`STREAM_DATA_W-1:0]  s_axis_tdata;
  logic                       s_axis_tready;
  logic [`AXI_ADDR_W-1:0]     m_axi_awaddr;
  logic [7:0]                 m_axi_awlen;
  logic                       m_axi_awvalid;
  logic                       m_axi_awready;
  logic [`AXI_DATA_W-1:0]     m_axi_wdata;
  logic [`AXI_DATA_W/8-1:0]   m_axi_wstrb;
  logic                       m_axi_wlast;
  logic                       m_axi_wvalid;
  logic                       m_axi_wready;
  logic                       m_axi_bvalid;
  logic                       m_axi_bready;

  integer      seed = 30683;
  int          ready_pct;                 // Chance per cycle of awready and wready
  int          gap_max;                   // Longest idle gap between stream beats
  logic        hold_b;                    // Withholds write responses
  logic [127:0] src_beats [$];            // Stream beats of the current transfer
  logic [31:0] exp_aw_addr [$];
  logic [7:0]  exp_aw_len [$];
  logic [31:0] exp_w_data [$];
  logic [3:0]  exp_w_strb [$];
  logic        exp_w_last [$];
  logic [31:0] xfer_addr [7];
  int          xfer_size [7];
  int          exp_b_total, aw_cnt, b_cnt, wlast_cnt, first_cnt, b_issued;
  int          done_cnt, max_held, chk_err, run_err, cycles, limit;
  int          test_pass, test_fail;
  int          fifo_occ;                  // Stream beats held inside the DUT
  int          w_lane;                    // Lane of the next W beat
  logic        done_due = 1'b0, w_first = 1'b1, first_counted = 1'b0;
  logic        aw_stalled = 1'b0, w_stalled = 1'b0;
  logic [31:0] aw_addr_hold, w_data_hold;
  logic [7:0]  aw_len_hold;
  logic [3:0]  w_strb_hold;
  logic        w_last_hold;

  axi_write_master axi_write_master_i (.*);

  initial begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;              // 8 ns period
  end

  ////////////////////////////////////////////////////////////
  // Memory side
  ////////////////////////////////////////////////////////////
  initial begin : ready_driver
    m_axi_awready = 1'b0;
    m_axi_wready  = 1'b0;
    forever begin
      @(posedge aclk);
      m_axi_awready <= ({$random(seed)} % 100) < ready_pct;
      m_axi_wready  <= ({$random(seed)} % 100) < ready_pct;
    end
  end

  // One response per burst, only once its address and its wlast are both through
  initial begin : b_responder
    int delay;
    m_axi_bvalid = 1'b0;
    forever begin
      @(posedge aclk);
      if (!reset && !hold_b && b_issued < wlast_cnt && b_issued < aw_cnt) begin
        delay = {$random(seed)} % 7;
        repeat (delay) @(posedge aclk);
        m_axi_bvalid <= 1'b1;
        b_issued++;
        @(posedge aclk);
        m_axi_bvalid <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////
  function automatic void build_expected(input logic [31:0] addr, input int size);
    int         beats;
    int         bursts;
    logic [3:0] last_strb;
    beats     = (size + 3) / 4;              // Whole AXI beats
    bursts    = (beats + 15) / 16;
    last_strb = (size % 4 == 0) ? 4'hF : 4'((1 << (size % 4)) - 1);
    for (int i = 0; i < bursts; i++) begin
      exp_aw_addr.push_back((addr & ~32'd63) + 32'(64 * i));
      exp_aw_len.push_back((i == bursts - 1) ? 8'((beats - 1) % 16) : 8'd15);
    end
    for (int k = 0; k < beats; k++) begin
      exp_w_data.push_back(src_beats[k / 4][32 * (k % 4) +: 32]);  // Lowest lane first
      exp_w_strb.push_back((k == beats - 1) ? last_strb : 4'hF);
      exp_w_last.push_back((k % 16 == 15) || (k == beats - 1));
    end
    exp_b_total += bursts;
  endfunction

  task automatic flag_mismatch(input string name, input logic [31:0] expv,
                               input logic [31:0] got);
    $display("MISMATCH at %0t ns: %s expected %h got %h", $time, name, expv, got);
    chk_err++;
  endtask

  ////////////////////////////////////////////////////////////
  // Compare, sampled mid-cycle ahead of the next edge
  ////////////////////////////////////////////////////////////
  always @(negedge aclk) begin
    if (!reset) begin
      if (ctrl_done !== done_due) flag_mismatch("ctrl_done", 32'(done_due), 32'(ctrl_done));
      if (ctrl_done) done_cnt++;
      done_due = 1'b0;
      if (s_axis_tready !== (fifo_occ != `FIFO_DEPTH))
        flag_mismatch("s_axis_tready", 32'(fifo_occ != `FIFO_DEPTH), 32'(s_axis_tready));
      if (m_axi_bready !== 1'b1) flag_mismatch("m_axi_bready", 32'd1, 32'(m_axi_bready));
      if (s_axis_tvalid && s_axis_tready) fifo_occ++;
      if (aw_stalled && (!m_axi_awvalid || m_axi_awaddr != aw_addr_hold ||
                         m_axi_awlen != aw_len_hold)) begin
        $display("%0t ns: AW channel changed while awready was low", $time);
        chk_err++;
      end
      if (w_stalled && (!m_axi_wvalid || m_axi_wdata != w_data_hold ||
                        m_axi_wstrb != w_strb_hold || m_axi_wlast != w_last_hold)) begin
        $display("%0t ns: W channel changed while wready was low", $time);
        chk_err++;
      end
      aw_stalled   = m_axi_awvalid && !m_axi_awready;
      aw_addr_hold = m_axi_awaddr;
      aw_len_hold  = m_axi_awlen;
      w_stalled    = m_axi_wvalid && !m_axi_wready;
      w_data_hold  = m_axi_wdata;
      w_strb_hold  = m_axi_wstrb;
      w_last_hold  = m_axi_wlast;
      if (m_axi_wvalid && w_first && !first_counted) begin  // Burst data now visible
        first_cnt++;
        first_counted = 1'b1;
      end
      if (m_axi_awvalid && m_axi_awready) begin
        if (exp_aw_addr.size() == 0) begin
          $display("%0t ns: AW handshake with no burst expected", $time);
          chk_err++;
        end else begin
          if (m_axi_awaddr != exp_aw_addr[0])
            flag_mismatch("m_axi_awaddr", exp_aw_addr[0], m_axi_awaddr);
          if (m_axi_awlen != exp_aw_len[0])
            flag_mismatch("m_axi_awlen", 32'(exp_aw_len[0]), 32'(m_axi_awlen));
          void'(exp_aw_addr.pop_front());
          void'(exp_aw_len.pop_front());
        end
        aw_cnt++;
      end
      if (m_axi_wvalid && m_axi_wready) begin
        if (exp_w_data.size() == 0) begin
          $display("%0t ns: W handshake with no beat expected", $time);
          chk_err++;
        end else begin
          if (m_axi_wdata != exp_w_data[0])
            flag_mismatch("m_axi_wdata", exp_w_data[0], m_axi_wdata);
          if (m_axi_wstrb != exp_w_strb[0])
            flag_mismatch("m_axi_wstrb", 32'(exp_w_strb[0]), 32'(m_axi_wstrb));
          if (m_axi_wlast != exp_w_last[0])
            flag_mismatch("m_axi_wlast", 32'(exp_w_last[0]), 32'(m_axi_wlast));
          if (w_lane == `LANES - 1 || exp_w_data.size() == 1) fifo_occ--;  // Beat drained
          w_lane = (exp_w_data.size() == 1) ? 0 : (w_lane + 1) % `LANES;
          void'(exp_w_data.pop_front());
          void'(exp_w_strb.pop_front());
          void'(exp_w_last.pop_front());
        end
        if (m_axi_wlast) wlast_cnt++;
        w_first       = m_axi_wlast;
        first_counted = 1'b0;
      end
      if (m_axi_bvalid && m_axi_bready) begin
        b_cnt++;
        if (b_cnt == exp_b_total) done_due = 1'b1;  // Done belongs in the next cycle
      end
      if (aw_cnt - b_cnt > `MAX_OUTSTANDING) begin
        $display("%0t ns: %0d bursts outstanding, above the limit", $time, aw_cnt - b_cnt);
        chk_err++;
      end
      if (hold_b && aw_cnt - b_cnt > max_held) max_held = aw_cnt - b_cnt;
      if (aw_cnt > first_cnt) begin
        $display("%0t ns: address issued before its burst data was visible", $time);
        chk_err++;
      end
    end
  end

  always @(posedge aclk) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("Timeout after %0d cycles, the transfer never completed", cycles);
      $display("Regression failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////
  task automatic send_stream(input int n);
    int   gap;
    logic taken;
    for (int i = 0; i < n; i++) begin
      gap = (gap_max == 0) ? 0 : {$random(seed)} % (gap_max + 1);
      if (gap != 0) begin
        s_axis_tvalid <= 1'b0;
        repeat (gap) @(posedge aclk);
      end
      s_axis_tvalid <= 1'b1;
      s_axis_tdata  <= src_beats[i];
      do begin
        @(negedge aclk);
        taken = s_axis_tready;           // Accepted at the coming edge
        @(posedge aclk);
      end while (!taken);
    end
    s_axis_tvalid <= 1'b0;
  endtask

  task automatic request_xfer(input logic [31:0] addr, input int size);
    ctrl_start <= 1'b1;
    ctrl_addr  <= addr;
    ctrl_size  <= 16'(size);
    @(posedge aclk);
    ctrl_start <= 1'b0;
  endtask

  task automatic run_xfer(input int idx);
    int beats;
    beats = (xfer_size[idx] + 3) / 4;
    src_beats.delete();
    for (int i = 0; i < (beats + 3) / 4; i++)
      src_beats.push_back({$random(seed), $random(seed), $random(seed), $random(seed)});
    build_expected(xfer_addr[idx], xfer_size[idx]);
    fork
      send_stream((beats + 3) / 4);
      request_xfer(xfer_addr[idx], xfer_size[idx]);
    join
    do @(negedge aclk); while (!ctrl_done);
    @(posedge aclk);
    if (exp_w_data.size() != 0 || exp_aw_addr.size() != 0) begin
      $display("Transfer %0d ended with expected beats or bursts never seen", idx);
      run_err++;
    end
  endtask

  task automatic log_test_result(input int num, input string name, input int errs_before);
    int errs;
    errs = chk_err + run_err - errs_before;
    $display("Test %0d %s: %s, %0d errors", num, name, (errs == 0) ? "ok" : "FAILED", errs);
    if (errs == 0) test_pass++;
    else test_fail++;
  endtask

  initial begin : main_seq
    int total_beats;
    int errs_before;
    int done_before;
    reset = 1'b1;
    ctrl_start = 1'b0;
    ctrl_addr = '0;
    ctrl_size = '0;
    s_axis_tvalid = 1'b0;
    s_axis_tdata = '0;
    hold_b = 1'b0;
    ready_pct = 100;
    gap_max = 0;
    xfer_addr[0] = 32'h0000_1236;        // Unaligned, 10 bytes
    xfer_size[0] = 10;
    xfer_addr[1] = 32'h0002_0040;
    xfer_size[1] = 1000;
    xfer_addr[2] = 32'h0003_0104;
    xfer_size[2] = 700;
    xfer_addr[3] = 32'h0004_0000;
    xfer_size[3] = 600;
    for (int i = 4; i < 7; i++) begin
      xfer_addr[i] = $random(seed);
      xfer_size[i] = 1 + {$random(seed)} % 1024;
    end
    total_beats = 0;
    for (int i = 0; i < 7; i++) total_beats += (xfer_size[i] + 3) / 4;
    limit = 20 * total_beats + 2000;
    repeat (2) @(posedge aclk);
    reset <= 1'b0;
    @(posedge aclk);

    errs_before = chk_err + run_err;
    run_xfer(0);
    log_test_result(1, "single short transfer", errs_before);

    errs_before = chk_err + run_err;
    run_xfer(1);
    log_test_result(2, "multi-burst transfer", errs_before);

    errs_before = chk_err + run_err;
    ready_pct = 50;
    gap_max = 3;
    run_xfer(2);
    log_test_result(3, "back-pressure", errs_before);

    errs_before = chk_err + run_err;
    ready_pct = 80;
    gap_max = 0;
    hold_b <= 1'b1;
    fork
      run_xfer(3);
      begin
        repeat (400) @(posedge aclk);
        hold_b <= 1'b0;
      end
    join
    if (max_held != `MAX_OUTSTANDING) begin
      $display("Outstanding limit never reached while responses were withheld");
      run_err++;
    end
    log_test_result(4, "outstanding limit and address-after-data", errs_before);

    errs_before = chk_err + run_err;
    done_before = done_cnt;
    ready_pct = 70;
    gap_max = 2;
    for (int i = 4; i < 7; i++) run_xfer(i);
    if (done_cnt - done_before != 3) begin
      $display("Expected 3 done pulses, saw %0d", done_cnt - done_before);
      run_err++;
    end
    log_test_result(5, "completion", errs_before);

    repeat (10) @(posedge aclk);         // Catch stray done pulses
    $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
             test_pass + test_fail, test_pass, test_fail, chk_err + run_err);
    if (test_fail == 0 && chk_err + run_err == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end
endmodule

/* flist.f */
+incdir+logic
logic/axi_wr_pkg.sv
logic/burst_plan_if.sv
logic/xfer_counter.sv
logic/beat_fifo.sv
logic/burst_setup.sv
logic/w_channel.sv
logic/aw_channel.sv
logic/resp_tracker.sv
logic/axi_write_master.sv
bench/tb_axi_write_master.sv

/* logic/aw_channel.sv */
`timescale 1ns/1ps
`include "axi_wr_consts.svh"

module aw_channel (
  input  logic                   aclk,
  input  logic                   reset,
  burst_plan_if.chan             plan,
  input  logic [`AXI_ADDR_W-1:0] base_addr,
  input  logic                   burst_first,
  input  logic                   aw_stall,
  output logic                   aw_accept,
  output logic [`AXI_ADDR_W-1:0] awaddr,
  output logic [7:0]             awlen,
  output logic                   awvalid,
  input  logic                   awready
);
  localparam int AHEAD_W = `BURSTS_W + 1;  // Every burst may have data first

  logic no_data_ahead;   // No burst waiting for its address
  logic aw_final;        // Current address is for the last burst

  assign aw_accept = awvalid && awready;

  ////////////////////////////////////////////////////////////
  // Gating on data presence and outstanding limit
  ////////////////////////////////////////////////////////////
  xfer_counter #(
    .width      (AHEAD_W),
    .init_value ('0)
  ) data_ahead_i (
    .aclk       (aclk),
    .reset      (reset),
    .load       (1'b0),
    .incr       (burst_first),
    .decr       (aw_accept),
    .load_value ('0),
    .count      (),
    .is_zero    (no_data_ahead)
  );

  always_ff @(posedge aclk) begin
    if (reset) awvalid <= 1'b0;
    else if (!awvalid && !no_data_ahead && !aw_stall) awvalid <= 1'b1;
    else if (awready) awvalid <= 1'b0;  // Gate counters settle before next raise
  end

  xfer_counter #(
    .width      (`BURSTS_W),
    .init_value ('0)
  ) bursts_left_i (
    .aclk       (aclk),
    .reset      (reset),
    .load       (plan.start),
    .incr       (1'b0),
    .decr       (aw_accept && !aw_final),
    .load_value (plan.num_bursts),
    .count      (),
    .is_zero    (aw_final)
  );

  always_ff @(posedge aclk) begin
    if (plan.start) awaddr <= base_addr;
    else if (aw_accept) awaddr <= awaddr + `AXI_ADDR_W'(`BURST_BYTES);  // Next burst
  end

  assign awlen = aw_final ? 8'(plan.final_len) : 8'(`BURST_LEN - 1);

  // Address payload held through a stall
  a_aw_stable: assert property (@(posedge aclk) disable iff (reset)
    (awvalid && !awready) |=> (awvalid && $stable(awaddr) && $stable(awlen)));
endmodule

/* logic/axi_wr_consts.svh */
`ifndef AXI_WR_CONSTS_SVH
`define AXI_WR_CONSTS_SVH

////////////////////////////////////////////////////////////
// Bus widths
////////////////////////////////////////////////////////////
`define AXI_ADDR_W      32                 // Byte address
`define AXI_DATA_W      32                 // One AXI beat, 4 bytes
`define AXI_BYTES_LOG   2
`define STREAM_DATA_W   128                // One stream beat
`define LANES           4                  // AXI words per stream beat
`define LANE_SEL_W      2
`define XFER_SIZE_W     16                 // Byte count

////////////////////////////////////////////////////////////
// Burst shape and flow control
////////////////////////////////////////////////////////////
`define BURST_LEN       16                 // Beats per full burst
`define BURST_LEN_LOG   4
`define BURST_BYTES     64
`define BURSTS_W        (`XFER_SIZE_W - `AXI_BYTES_LOG - `BURST_LEN_LOG)
`define FIFO_DEPTH      16                 // Stream beats buffered
`define MAX_OUTSTANDING 4                  // Bursts awaiting a response
`define OUTSTANDING_W   3

`endif

/* logic/axi_wr_pkg.sv */
`include "axi_wr_consts.svh"

package axi_wr_pkg;

  // Byte count, raw or split into burst, beat and byte fields
  typedef union packed {
    logic [`XFER_SIZE_W-1:0] raw;
    struct packed {
      logic [`BURSTS_W-1:0]      burst_idx;  // Full bursts
      logic [`BURST_LEN_LOG-1:0] beat_idx;   // Beat within last burst
      logic [`AXI_BYTES_LOG-1:0] byte_rem;   // Bytes past last whole beat
    } f;
  } xfer_size_u;

  // Stream beat, raw or as AXI lanes
  typedef union packed {
    logic [`STREAM_DATA_W-1:0]             raw;
    logic [`LANES-1:0][`AXI_DATA_W-1:0]    lanes;  // Lane 0 in the low bits
  } stream_beat_u;

endpackage

/* logic/axi_write_master.sv */
`timescale 1ns/1ps
`include "axi_wr_consts.svh"

module axi_write_master import axi_wr_pkg::*; (
  input  logic                       aclk,
  input  logic                       reset,
  // Transfer request
  input  logic                       ctrl_start,
  input  logic [`AXI_ADDR_W-1:0]     ctrl_addr,
  input  logic [`XFER_SIZE_W-1:0]    ctrl_size,
  output logic                       ctrl_done,
  // Stream input
  input  logic                       s_axis_tvalid,
  input  logic [`STREAM_DATA_W-1:0]  s_axis_tdata,
  output logic                       s_axis_tready,
  // AXI4 write address
  output logic [`AXI_ADDR_W-1:0]     m_axi_awaddr,
  output logic [7:0]                 m_axi_awlen,
  output logic                       m_axi_awvalid,
  input  logic                       m_axi_awready,
  // AXI4 write data
  output logic [`AXI_DATA_W-1:0]     m_axi_wdata,
  output logic [`AXI_DATA_W/8-1:0]   m_axi_wstrb,
  output logic                       m_axi_wlast,
  output logic                       m_axi_wvalid,
  input  logic                       m_axi_wready,
  // AXI4 write response
  input  logic                       m_axi_bvalid,
  output logic                       m_axi_bready
);
  logic [`AXI_ADDR_W-1:0] base_addr;
  stream_beat_u           fifo_data;
  logic                   fifo_valid;
  logic                   fifo_pop;
  logic                   burst_first;
  logic                   aw_accept;
  logic                   aw_stall;

  burst_plan_if plan_if ();

  burst_setup burst_setup_i (
    .aclk(aclk), .reset(reset), .ctrl_start(ctrl_start), .ctrl_addr(ctrl_addr),
    .ctrl_size(ctrl_size), .base_addr(base_addr), .plan(plan_if.setup)
  );

  beat_fifo beat_fifo_i (
    .aclk(aclk), .reset(reset), .wr_valid(s_axis_tvalid), .wr_data(s_axis_tdata),
    .wr_ready(s_axis_tready), .rd_pop(fifo_pop), .rd_data(fifo_data),
    .rd_valid(fifo_valid)
  );

  w_channel w_channel_i (
    .aclk(aclk), .reset(reset), .plan(plan_if.chan), .fifo_data(fifo_data),
    .fifo_valid(fifo_valid), .fifo_pop(fifo_pop), .wdata(m_axi_wdata),
    .wstrb(m_axi_wstrb), .wlast(m_axi_wlast), .wvalid(m_axi_wvalid),
    .wready(m_axi_wready), .burst_first(burst_first)
  );

  aw_channel aw_channel_i (
    .aclk(aclk), .reset(reset), .plan(plan_if.chan), .base_addr(base_addr),
    .burst_first(burst_first), .aw_stall(aw_stall), .aw_accept(aw_accept),
    .awaddr(m_axi_awaddr), .awlen(m_axi_awlen), .awvalid(m_axi_awvalid),
    .awready(m_axi_awready)
  );

  resp_tracker resp_tracker_i (
    .aclk(aclk), .reset(reset), .plan(plan_if.chan), .bvalid(m_axi_bvalid),
    .aw_accept(aw_accept), .bready(m_axi_bready), .aw_stall(aw_stall),
    .ctrl_done(ctrl_done)
  );
endmodule

/* logic/beat_fifo.sv */
`timescale 1ns/1ps
`include "axi_wr_consts.svh"

module beat_fifo import axi_wr_pkg::*; (
  input  logic         aclk,
  input  logic         reset,
  input  logic         wr_valid,
  input  stream_beat_u wr_data,
  output logic         wr_ready,
  input  logic         rd_pop,
  output stream_beat_u rd_data,
  output logic         rd_valid
);
  localparam int PTR_W = $clog2(`FIFO_DEPTH);

  stream_beat_u     mem [`FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;                // 0 .. FIFO_DEPTH
  logic             wr_en;

  assign wr_ready = (count != (PTR_W+1)'(`FIFO_DEPTH));
  assign wr_en    = wr_valid && wr_ready; // Only on a real handshake
  assign rd_valid = (count != '0);
  assign rd_data  = mem[rd_ptr];          // Head shown directly

  always_ff @(posedge aclk) begin
    if (wr_en) mem[wr_ptr] <= wr_data;
  end

  always_ff @(posedge aclk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + PTR_W'(1);
      if (rd_pop) rd_ptr <= rd_ptr + PTR_W'(1);
      if (wr_en && !rd_pop) count <= count + (PTR_W+1)'(1);
      else if (rd_pop && !wr_en) count <= count - (PTR_W+1)'(1);
    end
  end

  // Consumer pops only a visible head
  a_no_pop_empty: assert property (@(posedge aclk) disable iff (reset)
    rd_pop |-> rd_valid);

  // A write lands only in a free slot
  a_no_write_full: assert property (@(posedge aclk) disable iff (reset)
    wr_en |-> (count < (PTR_W+1)'(`FIFO_DEPTH)));
endmodule

/* logic/burst_plan_if.sv */
`timescale 1ns/1ps
`include "axi_wr_consts.svh"

// Decoded transfer plan, fixed from start until the next request
interface burst_plan_if;
  logic                         start;       // One-cycle pulse
  logic [`BURSTS_W-1:0]         num_bursts;  // Full bursts after the first
  logic [`BURST_LEN_LOG-1:0]    final_len;   // awlen of the last burst
  logic [`AXI_DATA_W/8-1:0]     final_strb;  // Strobe of the very last beat

  modport setup (
    output start, num_bursts, final_len, final_strb
  );

  modport chan (
    input start, num_bursts, final_len, final_strb
  );
endinterface

/* logic/burst_setup.sv */
`timescale 1ns/1ps
`include "axi_wr_consts.svh"

module burst_setup import axi_wr_pkg::*; (
  input  logic                    aclk,
  input  logic                    reset,
  input  logic                    ctrl_start,
  input  logic [`AXI_ADDR_W-1:0]  ctrl_addr,
  input  logic [`XFER_SIZE_W-1:0] ctrl_size,
  output logic [`AXI_ADDR_W-1:0]  base_addr,
  burst_plan_if.setup             plan
);
  localparam int LEN_W = `XFER_SIZE_W - `AXI_BYTES_LOG;  // Beat count width

  xfer_size_u                size_dec;
  logic [LEN_W-1:0]          total_len;   // Beats minus one
  logic [`AXI_BYTES_LOG-1:0] byte_rem;
  logic                      start_d1;

  assign size_dec.raw = ctrl_size;

  ////////////////////////////////////////////////////////////
  // Request capture
  ////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      base_addr <= ctrl_addr & ~(`AXI_ADDR_W'(`BURST_BYTES - 1));  // Burst aligned
      // Partial beat rounds up, so beats - 1 is just the word count
      total_len <= (size_dec.f.byte_rem != '0) ?
                   {size_dec.f.burst_idx, size_dec.f.beat_idx} :
                   {size_dec.f.burst_idx, size_dec.f.beat_idx} - LEN_W'(1);
      byte_rem  <= size_dec.f.byte_rem;
    end
  end

  always_ff @(posedge aclk) begin
    if (reset) begin
      start_d1   <= 1'b0;
      plan.start <= 1'b0;
    end else begin
      start_d1   <= ctrl_start;
      plan.start <= start_d1;  // Plan fields settled a cycle earlier
    end
  end

  assign plan.num_bursts = total_len[LEN_W-1 -: `BURSTS_W];
  assign plan.final_len  = total_len[`BURST_LEN_LOG-1:0];

  // Low byte_rem bytes, or the whole word when it divides evenly
  always_comb begin
    for (int i = 0; i < `AXI_DATA_W/8; i++)
      plan.final_strb[i] = (byte_rem == '0) || (i < int'(byte_rem));
  end

  a_size_nonzero: assert property (@(posedge aclk) disable iff (reset)
    ctrl_start |-> (ctrl_size != '0));
endmodule

/* logic/resp_tracker.sv */
`timescale 1ns/1ps
`include "axi_wr_consts.svh"

module resp_tracker (
  input  logic       aclk,
  input  logic       reset,
  burst_plan_if.chan plan,
  input  logic       bvalid,
  input  logic       aw_accept,
  output logic       bready,
  output logic       aw_stall,
  output logic       ctrl_done
);
  logic bxfer;
  logic b_final;   // Waiting on the last response

  assign bready = 1'b1;   // Responses always taken
  assign bxfer  = bvalid && bready;

  xfer_counter #(
    .width      (`BURSTS_W),
    .init_value ('0)
  ) resp_left_i (
    .aclk       (aclk),
    .reset      (reset),
    .load       (plan.start),
    .incr       (1'b0),
    .decr       (bxfer && !b_final),
    .load_value (plan.num_bursts),
    .count      (),
    .is_zero    (b_final)
  );

  // Free slots for bursts in flight
  xfer_counter #(
    .width      (`OUTSTANDING_W),
    .init_value (`OUTSTANDING_W'(`MAX_OUTSTANDING))
  ) vacancy_i (
    .aclk       (aclk),
    .reset      (reset),
    .load       (1'b0),
    .incr       (bxfer),
    .decr       (aw_accept),
    .load_value ('0),
    .count      (),
    .is_zero    (aw_stall)
  );

  always_ff @(posedge aclk) begin
    if (reset) ctrl_done <= 1'b0;
    else ctrl_done <= bxfer && b_final;  // One cycle after the last B
  end
endmodule

/* logic/w_channel.sv */
`timescale 1ns/1ps
`include "axi_wr_consts.svh"

module w_channel import axi_wr_pkg::*; (
  input  logic                     aclk,
  input  logic                     reset,
  burst_plan_if.chan               plan,
  input  stream_beat_u             fifo_data,
  input  logic                     fifo_valid,
  output logic                     fifo_pop,
  output logic [`AXI_DATA_W-1:0]   wdata,
  output logic [`AXI_DATA_W/8-1:0] wstrb,
  output logic                     wlast,
  output logic                     wvalid,
  input  logic                     wready,
  output logic                     burst_first   // First beat of a burst now visible
);
  logic                   running;      // Between start and the final beat
  logic [`LANE_SEL_W-1:0] lane_sel;
  logic                   wxfer;
  logic                   final_burst;
  logic                   final_beat;
  logic                   almost_final;
  logic                   beat_load;
  logic                   first;        // Next beat opens a burst
  logic                   first_seen;   // Its valid already reported
  logic [`BURSTS_W-1:0]   bursts_left;

  assign wvalid     = fifo_valid && running;
  assign wxfer      = wvalid && wready;
  assign wdata      = fifo_data.lanes[lane_sel];
  assign final_beat = wlast && final_burst;
  assign wstrb      = final_beat ? plan.final_strb : '1;
  assign fifo_pop   = wxfer && ((lane_sel == '1) || final_beat);  // Spare lanes dropped

  always_ff @(posedge aclk) begin
    if (reset) begin
      running  <= 1'b0;
      lane_sel <= '0;
    end else if (plan.start) begin
      running  <= 1'b1;
      lane_sel <= '0;    // Each transfer starts at lane 0
    end else if (wxfer) begin
      running  <= !final_beat;
      lane_sel <= final_beat ? '0 : lane_sel + `LANE_SEL_W'(1);
    end
  end

  ////////////////////////////////////////////////////////////
  // Burst bookkeeping
  ////////////////////////////////////////////////////////////
  assign almost_final = (bursts_left == `BURSTS_W'(1));
  assign beat_load    = plan.start || (wxfer && wlast && !final_burst);

  xfer_counter #(
    .width      (`BURST_LEN_LOG),
    .init_value (`BURST_LEN_LOG'(`BURST_LEN - 1))
  ) beats_left_i (
    .aclk       (aclk),
    .reset      (reset),
    .load       (beat_load),
    .incr       (1'b0),
    .decr       (wxfer && !wlast),   // Rests at zero after the final beat
    .load_value (((plan.start && plan.num_bursts == '0) || (!plan.start && almost_final)) ?
                 plan.final_len : `BURST_LEN_LOG'(`BURST_LEN - 1)),
    .count      (),
    .is_zero    (wlast)
  );

  xfer_counter #(
    .width      (`BURSTS_W),
    .init_value ('0)
  ) bursts_left_i (
    .aclk       (aclk),
    .reset      (reset),
    .load       (plan.start),
    .incr       (1'b0),
    .decr       (wxfer && wlast && !final_burst),
    .load_value (plan.num_bursts),
    .count      (bursts_left),
    .is_zero    (final_burst)
  );

  // A handshake frees the slot, so a back-to-back first beat still reports
  always_ff @(posedge aclk) begin
    if (reset) begin
      first      <= 1'b1;
      first_seen <= 1'b0;
    end else begin
      if (wxfer) first <= wlast;
      if (wxfer) first_seen <= 1'b0;
      else if (wvalid && first) first_seen <= 1'b1;
    end
  end

  assign burst_first = wvalid && first && !first_seen;
endmodule

/* logic/xfer_counter.sv */
`timescale 1ns/1ps

module xfer_counter #(
  parameter int               width      = 4,
  parameter logic [width-1:0] init_value = '0
) (
  input  logic             aclk,
  input  logic             reset,
  input  logic             load,        // Wins over incr and decr
  input  logic             incr,
  input  logic             decr,
  input  logic [width-1:0] load_value,
  output logic [width-1:0] count,
  output logic             is_zero
);
  always_ff @(posedge aclk) begin
    if (reset) count <= init_value;
    else if (load) count <= load_value;
    else if (incr && !decr) count <= count + width'(1);
    else if (decr && !incr) count <= count - width'(1);  // Both at once cancel
  end

  assign is_zero = (count == '0);

  // Callers must never step below zero
  a_no_underflow: assert property (@(posedge aclk) disable iff (reset)
    (decr && !incr && !load) |-> !is_zero);
endmodule

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f flist.f \
  --top-module tb_axi_write_master -o sim_axi_write_master
./obj_dir/sim_axi_write_master | tee sim.log

if grep -q "Regression failed" sim.log; then
  exit 1
fi
grep -q "Regression passed" sim.log
